/* all.f */
+incdir+logic
logic/issue_pkg.sv
logic/instr_queue.sv
logic/instr_class_decoder.sv
logic/pair_issue_select.sv
logic/issue_queue_top.sv
verification/issue_queue_tb.sv

/* logic/instr_class_decoder.sv */
// decodes one MIPS instruction word into the class flags used by the dual-issue rule
`timescale 1ns/1ps

module instr_class_decoder (
    input  issue_pkg::word_t    instr,
    output logic                mem_access,
    output logic                is_branch,
    output logic                is_jump,
    output logic                reg_write,
    output logic                hi_write,
    output logic                lo_write,
    output logic                need_rs,
    output logic                need_rt,
    output logic                need_hi,
    output logic                need_lo,
    output logic                cp0_related,
    output issue_pkg::reg_num_t dst_reg
);
    import issue_pkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    reg_num_t   rs;
    reg_num_t   rt;
    reg_num_t   rd;
    reg_dst_e   dst_sel;

    assign op    = instr[31:26];
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];
    assign funct = instr[5:0];

    always_comb
    begin
        mem_access  = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        reg_write   = 1'b0;
        hi_write    = 1'b0;
        lo_write    = 1'b0;
        need_rs     = 1'b0;
        need_rt     = 1'b0;
        need_hi     = 1'b0;
        need_lo     = 1'b0;
        cp0_related = 1'b0;
        dst_sel     = DST_NONE;
        case (op)
            6'h00:
            begin
                case (funct)
                    // shifts by a constant only read rt
                    6'h00, 6'h02, 6'h03:
                    begin
                        reg_write = 1'b1;
                        dst_sel   = DST_RD;
                        need_rt   = 1'b1;
                    end
                    6'h04, 6'h06, 6'h07, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
                    6'h27, 6'h2a, 6'h2b:
                    begin
                        reg_write = 1'b1;
                        dst_sel   = DST_RD;
                        need_rs   = 1'b1;
                        need_rt   = 1'b1;
                    end
                    6'h08:
                    begin
                        is_jump = 1'b1;
                        need_rs = 1'b1;
                    end
                    6'h09:
                    begin
                        is_jump   = 1'b1;
                        reg_write = 1'b1;
                        dst_sel   = DST_RD;
                        need_rs   = 1'b1;
                    end
                    6'h0c, 6'h0d: cp0_related = 1'b1;
                    6'h10:
                    begin
                        reg_write = 1'b1;
                        dst_sel   = DST_RD;
                        need_hi   = 1'b1;
                    end
                    6'h11:
                    begin
                        hi_write = 1'b1;
                        need_rs  = 1'b1;
                    end
                    6'h12:
                    begin
                        reg_write = 1'b1;
                        dst_sel   = DST_RD;
                        need_lo   = 1'b1;
                    end
                    6'h13:
                    begin
                        lo_write = 1'b1;
                        need_rs  = 1'b1;
                    end
                    // mult, multu, div, divu
                    6'h18, 6'h19, 6'h1a, 6'h1b:
                    begin
                        hi_write = 1'b1;
                        lo_write = 1'b1;
                        need_rs  = 1'b1;
                        need_rt  = 1'b1;
                    end
                    default: ;
                endcase
            end
            // REGIMM, the link forms also write r31
            6'h01:
            begin
                if (rt == 5'h00 || rt == 5'h01)
                begin
                    is_branch = 1'b1;
                    need_rs   = 1'b1;
                end
                else if (rt == 5'h10 || rt == 5'h11)
                begin
                    is_branch = 1'b1;
                    need_rs   = 1'b1;
                    reg_write = 1'b1;
                    dst_sel   = DST_R31;
                end
            end
            6'h02: is_jump = 1'b1;
            6'h03:
            begin
                is_jump   = 1'b1;
                reg_write = 1'b1;
                dst_sel   = DST_R31;
            end
            6'h04, 6'h05:
            begin
                is_branch = 1'b1;
                need_rs   = 1'b1;
                need_rt   = 1'b1;
            end
            6'h06, 6'h07:
            begin
                is_branch = 1'b1;
                need_rs   = 1'b1;
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f:
            begin
                reg_write = 1'b1;
                dst_sel   = DST_RT;
                need_rs   = 1'b1;
            end
            // mfc0, mtc0 and eret
            6'h10:
            begin
                if (rs == 5'h00 || rs == 5'h04 || (rs == 5'h10 && funct == 6'h18))
                    cp0_related = 1'b1;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25:
            begin
                mem_access = 1'b1;
                reg_write  = 1'b1;
                dst_sel    = DST_RT;
                need_rs    = 1'b1;
            end
            6'h28, 6'h29, 6'h2b:
            begin
                mem_access = 1'b1;
                need_rs    = 1'b1;
                need_rt    = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb
    begin
        case (dst_sel)
            DST_RT:  dst_reg = rt;
            DST_RD:  dst_reg = rd;
            DST_R31: dst_reg = 5'd31;
            default: dst_reg = 5'd0;
        endcase
    end

endmodule

/* logic/instr_queue.sv */
// circular instruction store between fetch and decode, shows the two head entries
`timescale 1ns/1ps
`include "issue_defines.svh"

module instr_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wen1,
    input  logic                  wen2,
    input  issue_pkg::word_t      addr1,
    input  issue_pkg::word_t      addr2,
    input  issue_pkg::word_t      instr1,
    input  issue_pkg::word_t      instr2,
    input  logic                  addr_err1,
    input  logic                  addr_err2,
    input  issue_pkg::issue_count_t issue_count,
    output issue_pkg::word_t      head_addr0,
    output issue_pkg::word_t      head_addr1,
    output issue_pkg::word_t      head_instr0,
    output issue_pkg::word_t      head_instr1,
    output logic                  head_addr_err0,
    output logic                  head_addr_err1,
    output issue_pkg::queue_ptr_t occupancy,
    output logic                  queue_full,
    output logic                  queue_nearly_full
);
    import issue_pkg::*;

    localparam int IDX_W = `ISSUE_PTR_WIDTH - 1;

    word_t                         addr_mem  [`ISSUE_QUEUE_DEPTH];
    word_t                         instr_mem [`ISSUE_QUEUE_DEPTH];
    logic [`ISSUE_QUEUE_DEPTH-1:0] err_mem;

    queue_ptr_t       wr_ptr;
    queue_ptr_t       rd_ptr;
    logic [IDX_W-1:0] wr_idx0;
    logic [IDX_W-1:0] wr_idx1;
    logic [IDX_W-1:0] rd_idx0;
    logic [IDX_W-1:0] rd_idx1;
    issue_count_t     wr_count;

    // first free entry takes instruction 1 if strobed, else instruction 2
    word_t first_addr;
    word_t first_instr;
    logic  first_err;

    assign wr_idx0 = wr_ptr[IDX_W-1:0];
    assign wr_idx1 = wr_idx0 + 1'b1;
    assign rd_idx0 = rd_ptr[IDX_W-1:0];
    assign rd_idx1 = rd_idx0 + 1'b1;

    assign wr_count    = {1'b0, wen1} + {1'b0, wen2};
    assign first_addr  = wen1 ? addr1 : addr2;
    assign first_instr = wen1 ? instr1 : instr2;
    assign first_err   = wen1 ? addr_err1 : addr_err2;

    always_ff @(posedge clk)
    begin
        if (wen1 || wen2)
        begin
            addr_mem[wr_idx0]  <= first_addr;
            instr_mem[wr_idx0] <= first_instr;
            err_mem[wr_idx0]   <= first_err;
        end
        // instruction 2 lands behind instruction 1 on a double write
        if (wen1 && wen2)
        begin
            addr_mem[wr_idx1]  <= addr2;
            instr_mem[wr_idx1] <= instr2;
            err_mem[wr_idx1]   <= addr_err2;
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + queue_ptr_t'(wr_count);
            rd_ptr <= rd_ptr + queue_ptr_t'(issue_count);
        end
    end

    // wrap bit makes the difference run from 0 to the full depth
    assign occupancy         = wr_ptr - rd_ptr;
    assign queue_full        = (occupancy == queue_ptr_t'(`ISSUE_QUEUE_DEPTH));
    assign queue_nearly_full = (occupancy >= queue_ptr_t'(`ISSUE_QUEUE_DEPTH - 1));

    assign head_addr0     = addr_mem[rd_idx0];
    assign head_addr1     = addr_mem[rd_idx1];
    assign head_instr0    = instr_mem[rd_idx0];
    assign head_instr1    = instr_mem[rd_idx1];
    assign head_addr_err0 = err_mem[rd_idx0];
    assign head_addr_err1 = err_mem[rd_idx1];

    // fetch has to honour both flags, the queue never drops an entry
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!reset)
        !(queue_full && (wen1 || wen2)) && !(queue_nearly_full && wen1 && wen2)
    )
    else $error("fetch wrote past the free space of the queue");

    // the selector may only drain what is held
    a_issue_in_range: assert property (
        @(posedge clk) disable iff (!reset)
        queue_ptr_t'(issue_count) <= occupancy
    )
    else $error("issue count %0d above occupancy %0d", issue_count, occupancy);

endmodule

/* logic/issue_defines.svh */
// sizing macros for the issue queue, included by the package and by the queue
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// number of queue entries, any power of two from 4 upward
`define ISSUE_QUEUE_DEPTH 16

// log2 of the depth plus one wrap bit
`define ISSUE_PTR_WIDTH 5

// instructions written or issued per cycle at most
`define ISSUE_WIDTH 2

`endif

/* logic/issue_pkg.sv */
// shared types of the issue queue, imported by every RTL module and the testbench
package issue_pkg;

    `include "issue_defines.svh"

    // instruction word or PC
    typedef logic [31:0] word_t;

    // general register number
    typedef logic [4:0] reg_num_t;

    // read or write pointer, top bit is the wrap bit
    typedef logic [`ISSUE_PTR_WIDTH-1:0] queue_ptr_t;

    // 0, 1 or 2 instructions
    typedef logic [1:0] issue_count_t;

    // where an instruction writes its result
    typedef enum logic [1:0] {
        DST_RT,
        DST_RD,
        DST_R31,
        DST_NONE
    } reg_dst_e;

endpackage

/* logic/issue_queue_top.sv */
// top of the issue queue: queue, one class decoder per head position, pair selector
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_queue_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_wen1,
    input  logic                    fetch_wen2,
    input  issue_pkg::word_t        fetch_addr1,
    input  issue_pkg::word_t        fetch_addr2,
    input  issue_pkg::word_t        fetch_instr1,
    input  issue_pkg::word_t        fetch_instr2,
    input  logic                    fetch_addr_err1,
    input  logic                    fetch_addr_err2,
    input  logic                    issue_stall,
    output logic                    queue_full,
    output logic                    queue_nearly_full,
    output issue_pkg::issue_count_t issue_count,
    output issue_pkg::word_t        issue_addr_alpha,
    output issue_pkg::word_t        issue_addr_beta,
    output issue_pkg::word_t        issue_instr_alpha,
    output issue_pkg::word_t        issue_instr_beta,
    output logic                    issue_addr_err_alpha,
    output logic                    issue_addr_err_beta
);
    import issue_pkg::*;

    word_t      head_addr  [`ISSUE_WIDTH];
    word_t      head_instr [`ISSUE_WIDTH];
    logic       head_addr_err [`ISSUE_WIDTH];
    queue_ptr_t occupancy;

    // decoder flags, index 0 is alpha and index 1 is beta
    logic [`ISSUE_WIDTH-1:0] mem_access;
    logic [`ISSUE_WIDTH-1:0] is_branch;
    logic [`ISSUE_WIDTH-1:0] is_jump;
    logic [`ISSUE_WIDTH-1:0] reg_write;
    logic [`ISSUE_WIDTH-1:0] hi_write;
    logic [`ISSUE_WIDTH-1:0] lo_write;
    logic [`ISSUE_WIDTH-1:0] need_rs;
    logic [`ISSUE_WIDTH-1:0] need_rt;
    logic [`ISSUE_WIDTH-1:0] need_hi;
    logic [`ISSUE_WIDTH-1:0] need_lo;
    logic [`ISSUE_WIDTH-1:0] cp0_related;
    reg_num_t                dst_reg [`ISSUE_WIDTH];

    instr_queue u_queue (
        .clk               (clk),
        .reset             (reset),
        .wen1              (fetch_wen1),
        .wen2              (fetch_wen2),
        .addr1             (fetch_addr1),
        .addr2             (fetch_addr2),
        .instr1            (fetch_instr1),
        .instr2            (fetch_instr2),
        .addr_err1         (fetch_addr_err1),
        .addr_err2         (fetch_addr_err2),
        .issue_count       (issue_count),
        .head_addr0        (head_addr[0]),
        .head_addr1        (head_addr[1]),
        .head_instr0       (head_instr[0]),
        .head_instr1       (head_instr[1]),
        .head_addr_err0    (head_addr_err[0]),
        .head_addr_err1    (head_addr_err[1]),
        .occupancy         (occupancy),
        .queue_full        (queue_full),
        .queue_nearly_full (queue_nearly_full)
    );

    for (genvar k = 0; k < `ISSUE_WIDTH; k++)
    begin : g_decode
        instr_class_decoder u_decoder (
            .instr       (head_instr[k]),
            .mem_access  (mem_access[k]),
            .is_branch   (is_branch[k]),
            .is_jump     (is_jump[k]),
            .reg_write   (reg_write[k]),
            .hi_write    (hi_write[k]),
            .lo_write    (lo_write[k]),
            .need_rs     (need_rs[k]),
            .need_rt     (need_rt[k]),
            .need_hi     (need_hi[k]),
            .need_lo     (need_lo[k]),
            .cp0_related (cp0_related[k]),
            .dst_reg     (dst_reg[k])
        );
    end

    pair_issue_select u_select (
        .stall                (issue_stall),
        .occupancy            (occupancy),
        .head_addr0           (head_addr[0]),
        .head_addr1           (head_addr[1]),
        .head_instr0          (head_instr[0]),
        .head_instr1          (head_instr[1]),
        .head_addr_err0       (head_addr_err[0]),
        .head_addr_err1       (head_addr_err[1]),
        .alpha_reg_write      (reg_write[0]),
        .alpha_hi_write       (hi_write[0]),
        .alpha_lo_write       (lo_write[0]),
        .alpha_cp0_related    (cp0_related[0]),
        .alpha_dst_reg        (dst_reg[0]),
        .beta_mem_access      (mem_access[1]),
        .beta_is_branch       (is_branch[1]),
        .beta_is_jump         (is_jump[1]),
        .beta_need_rs         (need_rs[1]),
        .beta_need_rt         (need_rt[1]),
        .beta_need_hi         (need_hi[1]),
        .beta_need_lo         (need_lo[1]),
        .beta_cp0_related     (cp0_related[1]),
        .issue_count          (issue_count),
        .issue_addr_alpha     (issue_addr_alpha),
        .issue_addr_beta      (issue_addr_beta),
        .issue_instr_alpha    (issue_instr_alpha),
        .issue_instr_beta     (issue_instr_beta),
        .issue_addr_err_alpha (issue_addr_err_alpha),
        .issue_addr_err_beta  (issue_addr_err_beta)
    );

endmodule

/* logic/pair_issue_select.sv */
// dual-issue decision over the two head entries, drives the alpha and beta slots
`timescale 1ns/1ps

module pair_issue_select (
    input  logic                    stall,
    input  issue_pkg::queue_ptr_t   occupancy,
    input  issue_pkg::word_t        head_addr0,
    input  issue_pkg::word_t        head_addr1,
    input  issue_pkg::word_t        head_instr0,
    input  issue_pkg::word_t        head_instr1,
    input  logic                    head_addr_err0,
    input  logic                    head_addr_err1,
    input  logic                    alpha_reg_write,
    input  logic                    alpha_hi_write,
    input  logic                    alpha_lo_write,
    input  logic                    alpha_cp0_related,
    input  issue_pkg::reg_num_t     alpha_dst_reg,
    input  logic                    beta_mem_access,
    input  logic                    beta_is_branch,
    input  logic                    beta_is_jump,
    input  logic                    beta_need_rs,
    input  logic                    beta_need_rt,
    input  logic                    beta_need_hi,
    input  logic                    beta_need_lo,
    input  logic                    beta_cp0_related,
    output issue_pkg::issue_count_t issue_count,
    output issue_pkg::word_t        issue_addr_alpha,
    output issue_pkg::word_t        issue_addr_beta,
    output issue_pkg::word_t        issue_instr_alpha,
    output issue_pkg::word_t        issue_instr_beta,
    output logic                    issue_addr_err_alpha,
    output logic                    issue_addr_err_beta
);
    import issue_pkg::*;

    reg_num_t   beta_rs;
    reg_num_t   beta_rt;
    logic [5:0] beta_op;
    logic       beta_op_branch;
    logic       reg_hazard;
    logic       single_only;
    logic       alpha_go;
    logic       beta_go;

    assign beta_rs = head_instr1[25:21];
    assign beta_rt = head_instr1[20:16];
    assign beta_op = head_instr1[31:26];

    // branch opcodes taken from the beta word itself
    assign beta_op_branch = (beta_op inside {6'h04, 6'h05, 6'h06, 6'h07})
        || (beta_op == 6'h01 && (beta_rt inside {5'h00, 5'h01, 5'h10, 5'h11}));

    // alpha result feeds a source that beta reads
    assign reg_hazard = alpha_reg_write
        && ((alpha_dst_reg == beta_rs && beta_need_rs)
        || (alpha_dst_reg == beta_rt && beta_need_rt));

    assign single_only = beta_is_branch || beta_is_jump || beta_mem_access || reg_hazard
        || (alpha_hi_write && beta_need_hi) || (alpha_lo_write && beta_need_lo)
        || alpha_cp0_related || beta_cp0_related;

    always_comb
    begin
        if (stall || occupancy == '0)
            issue_count = 2'd0;
        else if (occupancy == queue_ptr_t'(1) || single_only)
            issue_count = 2'd1;
        else
            issue_count = 2'd2;
    end

    assign alpha_go = (issue_count != 2'd0);
    assign beta_go  = (issue_count == 2'd2);

    // slots left idle show zeros
    assign issue_addr_alpha     = alpha_go ? head_addr0 : '0;
    assign issue_instr_alpha    = alpha_go ? head_instr0 : '0;
    assign issue_addr_err_alpha = alpha_go & head_addr_err0;
    assign issue_addr_beta      = beta_go ? head_addr1 : '0;
    assign issue_instr_beta     = beta_go ? head_instr1 : '0;
    assign issue_addr_err_beta  = beta_go & head_addr_err1;

    // a branch in beta would lose its delay slot pairing
    always_comb
    begin
        a_no_branch_in_beta: assert final (!(beta_go && beta_op_branch))
        else $error("pair issued with a branch in the beta slot");
    end

endmodule

/* verification/issue_queue_tb.sv */
// testbench for the issue queue: random fetch and stall against a queue and decode model
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_queue_tb;
    import issue_pkg::*;

    localparam int DEPTH          = `ISSUE_QUEUE_DEPTH;
    localparam int RESET_CYCLES   = 8;
    localparam int FILL_CYCLES    = 24;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int DRAIN_CYCLES   = 24;
    localparam int STIM_CYCLES    = RESET_CYCLES + FILL_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2;

    // bit positions in the reference decode vector, dst register sits in [15:11]
    localparam int F_MEM = 0;
    localparam int F_BR  = 1;
    localparam int F_JMP = 2;
    localparam int F_RW  = 3;
    localparam int F_HW  = 4;
    localparam int F_LW  = 5;
    localparam int F_NRS = 6;
    localparam int F_NRT = 7;
    localparam int F_NHI = 8;
    localparam int F_NLO = 9;
    localparam int F_CP0 = 10;

    logic clk;
    logic reset;
    logic fetch_wen1;
    logic fetch_wen2;
    word_t fetch_addr1;
    word_t fetch_addr2;
    word_t fetch_instr1;
    word_t fetch_instr2;
    logic fetch_addr_err1;
    logic fetch_addr_err2;
    logic issue_stall;
    logic queue_full;
    logic queue_nearly_full;
    issue_count_t issue_count;
    word_t issue_addr_alpha;
    word_t issue_addr_beta;
    word_t issue_instr_alpha;
    word_t issue_instr_beta;
    logic issue_addr_err_alpha;
    logic issue_addr_err_beta;

    // reference queue, pointers count up without wrapping
    word_t m_addr [DEPTH];
    word_t m_instr [DEPTH];
    logic m_err [DEPTH];
    int m_wr;
    int m_rd;
    int rd0;
    int rd1;
    issue_count_t exp_count;
    logic [64:0] exp_alpha;
    logic [64:0] exp_beta;

    logic [31:0] lfsr = 32'h7ce6_d928;
    word_t next_pc = 32'h0040_0000;
    int errors = 0;
    int checked = 0;
    int cycles = 0;

    issue_queue_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // one instruction per class, upper half of sel favours plain ALU ops
    function automatic word_t make_instr(input logic [4:0] sel, input reg_num_t rs,
                                         input reg_num_t rt, input reg_num_t rd);
        logic [3:0] k;
        k = sel[4] ? (sel[0] ? 4'd0 : 4'd2) : sel[3:0];
        case (k)
            4'd0: return {6'h00, rs, rt, rd, 5'd0, 6'h21};
            4'd1: return {6'h00, 5'd0, rt, rd, 5'd3, 6'h00};
            4'd2: return {6'h09, rs, rt, rd, 5'd0, 6'h04};
            4'd3: return {6'h23, rs, rt, 16'h0010};
            4'd4: return {6'h2b, rs, rt, 16'h0020};
            4'd5: return {6'h04, rs, rt, 16'h0004};
            4'd6: return {6'h01, rs, 5'h10, 16'h0008};
            4'd7: return {6'h02, 26'h000_0400};
            4'd8: return {6'h00, rs, 5'd0, rd, 5'd0, 6'h09};
            4'd9: return {6'h00, rs, rt, 10'd0, 6'h18};
            4'd10: return {6'h00, 10'd0, rd, 5'd0, 6'h10};
            4'd11: return {6'h00, 10'd0, rd, 5'd0, 6'h12};
            4'd12: return {6'h00, rs, 15'd0, 6'h11};
            4'd13: return {6'h00, rs, 15'd0, 6'h13};
            4'd14: return {6'h10, 5'h00, rt, rd, 11'd0};
            default: return {6'h00, 20'd0, 6'h0c};
        endcase
    endfunction

    function automatic logic [15:0] ref_flags(input word_t w);
        logic [5:0] op;
        logic [5:0] fn;
        logic rtype, shift_c, alu_r, mf, muldiv, jalr, regimm, link, imm, load, store;
        logic [15:0] f;
        op      = w[31:26];
        fn      = w[5:0];
        rtype   = (op == 6'h00);
        shift_c = rtype && (fn inside {6'h00, 6'h02, 6'h03});
        alu_r   = rtype && (fn inside {6'h04, 6'h06, 6'h07, [6'h20:6'h27], 6'h2a, 6'h2b});
        mf      = rtype && (fn == 6'h10 || fn == 6'h12);
        muldiv  = rtype && (fn inside {[6'h18:6'h1b]});
        jalr    = rtype && (fn == 6'h09);
        regimm  = (op == 6'h01) && (w[20:16] inside {5'h00, 5'h01, 5'h10, 5'h11});
        link    = regimm && w[20];
        imm     = op inside {[6'h08:6'h0f]};
        load    = op inside {6'h20, 6'h21, 6'h23, 6'h24, 6'h25};
        store   = op inside {6'h28, 6'h29, 6'h2b};
        f = '0;
        f[F_MEM] = load || store;
        f[F_BR]  = regimm || (op inside {[6'h04:6'h07]});
        f[F_JMP] = op == 6'h02 || op == 6'h03 || (rtype && fn == 6'h08) || jalr;
        f[F_RW]  = alu_r || shift_c || mf || imm || load || op == 6'h03 || jalr || link;
        f[F_HW]  = muldiv || (rtype && fn == 6'h11);
        f[F_LW]  = muldiv || (rtype && fn == 6'h13);
        f[F_NRS] = alu_r || imm || load || store || muldiv || f[F_BR]
            || (rtype && (fn inside {6'h08, 6'h09, 6'h11, 6'h13}));
        f[F_NRT] = alu_r || shift_c || store || muldiv || op == 6'h04 || op == 6'h05;
        f[F_NHI] = rtype && fn == 6'h10;
        f[F_NLO] = rtype && fn == 6'h12;
        f[F_CP0] = (rtype && (fn == 6'h0c || fn == 6'h0d)) || (op == 6'h10
            && (w[25:21] == 5'h00 || w[25:21] == 5'h04 || (w[25:21] == 5'h10 && fn == 6'h18)));
        if (op == 6'h03 || link)
            f[15:11] = 5'd31;
        else if (imm || load)
            f[15:11] = w[20:16];
        else if (alu_r || shift_c || mf || jalr)
            f[15:11] = w[15:11];
        return f;
    endfunction

    function automatic issue_count_t expected_count(input logic stall, input int occ,
                                                    input word_t a, input word_t b);
        logic [15:0] fa;
        logic [15:0] fb;
        logic dep;
        fa = ref_flags(a);
        fb = ref_flags(b);
        if (stall || occ == 0)
            return 2'd0;
        if (occ == 1)
            return 2'd1;
        dep = fa[F_RW] && ((fa[15:11] == b[25:21] && fb[F_NRS])
            || (fa[15:11] == b[20:16] && fb[F_NRT]));
        if (fb[F_BR] || fb[F_JMP] || fb[F_MEM] || dep || (fa[F_HW] && fb[F_NHI])
            || (fa[F_LW] && fb[F_NLO]) || fa[F_CP0] || fb[F_CP0])
            return 2'd1;
        return 2'd2;
    endfunction

    assign rd0 = m_rd % DEPTH;
    assign rd1 = (m_rd + 1) % DEPTH;
    assign exp_count = expected_count(issue_stall, m_wr - m_rd, m_instr[rd0], m_instr[rd1]);
    assign exp_alpha = (exp_count != 2'd0) ? {m_err[rd0], m_addr[rd0], m_instr[rd0]} : '0;
    assign exp_beta  = (exp_count == 2'd2) ? {m_err[rd1], m_addr[rd1], m_instr[rd1]} : '0;

    always @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            m_wr <= 0;
            m_rd <= 0;
        end
        else
        begin
            if (fetch_wen1)
            begin
                m_addr[m_wr % DEPTH]  <= fetch_addr1;
                m_instr[m_wr % DEPTH] <= fetch_instr1;
                m_err[m_wr % DEPTH]   <= fetch_addr_err1;
            end
            if (fetch_wen2)
            begin
                m_addr[(m_wr + int'(fetch_wen1)) % DEPTH]  <= fetch_addr2;
                m_instr[(m_wr + int'(fetch_wen1)) % DEPTH] <= fetch_instr2;
                m_err[(m_wr + int'(fetch_wen1)) % DEPTH]   <= fetch_addr_err2;
            end
            m_wr <= m_wr + int'(fetch_wen1) + int'(fetch_wen2);
            m_rd <= m_rd + int'(exp_count);
            checked <= checked + 1;
        end
    end

    task automatic report_mismatch(input string what, input logic [64:0] got,
                                   input logic [64:0] want);
        errors++;
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    a_count: assert property (@(posedge clk) disable iff (!reset) issue_count === exp_count)
        else report_mismatch("issue_count", $sampled(issue_count), $sampled(exp_count));

    a_flags: assert property (@(posedge clk) disable iff (!reset)
        {queue_full, queue_nearly_full} === {m_wr - m_rd == DEPTH, m_wr - m_rd >= DEPTH - 1})
        else report_mismatch("full flags", $sampled({queue_full, queue_nearly_full}),
                             $sampled({m_wr - m_rd == DEPTH, m_wr - m_rd >= DEPTH - 1}));

    a_alpha: assert property (@(posedge clk) disable iff (!reset)
        {issue_addr_err_alpha, issue_addr_alpha, issue_instr_alpha} === exp_alpha)
        else report_mismatch("alpha slot",
            $sampled({issue_addr_err_alpha, issue_addr_alpha, issue_instr_alpha}),
            $sampled(exp_alpha));

    a_beta: assert property (@(posedge clk) disable iff (!reset)
        {issue_addr_err_beta, issue_addr_beta, issue_instr_beta} === exp_beta)
        else report_mismatch("beta slot",
            $sampled({issue_addr_err_beta, issue_addr_beta, issue_instr_beta}),
            $sampled(exp_beta));

    // picks the next fetch pair, leaving room for the write still in flight
    task automatic drive_cycle(input logic hold);
        int occ_next;
        logic [1:0] w;
        occ_next = m_wr - m_rd + int'(fetch_wen1) + int'(fetch_wen2) - int'(exp_count);
        w = lfsr_bits(2);
        if (DEPTH - occ_next < 1)
            w = 2'b00;
        else if (DEPTH - occ_next < 2 && w == 2'b11)
            w = 2'b01;
        fetch_wen1      <= w[0];
        fetch_wen2      <= w[1];
        fetch_addr1     <= next_pc;
        fetch_addr2     <= next_pc + 32'd4;
        fetch_instr1    <= make_instr(5'(lfsr_bits(5)), 5'(lfsr_bits(2)), 5'(lfsr_bits(2)),
                                      5'(lfsr_bits(2)));
        fetch_instr2    <= make_instr(5'(lfsr_bits(5)), 5'(lfsr_bits(2)), 5'(lfsr_bits(2)),
                                      5'(lfsr_bits(2)));
        fetch_addr_err1 <= (lfsr_bits(3) == 0);
        fetch_addr_err2 <= (lfsr_bits(3) == 0);
        issue_stall     <= hold || (lfsr_bits(2) == 0);
        next_pc = next_pc + 32'd8;
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        reset           = 1'b0;
        fetch_wen1      = 1'b0;
        fetch_wen2      = 1'b0;
        fetch_addr1     = '0;
        fetch_addr2     = '0;
        fetch_instr1    = '0;
        fetch_instr2    = '0;
        fetch_addr_err1 = 1'b0;
        fetch_addr_err2 = 1'b0;
        issue_stall     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        // stalled fill up to full
        while (!queue_full)
        begin
            @(posedge clk);
            drive_cycle(1'b1);
        end
        repeat (RANDOM_CYCLES)
        begin
            @(posedge clk);
            drive_cycle(1'b0);
        end
        @(posedge clk);
        fetch_wen1  <= 1'b0;
        fetch_wen2  <= 1'b0;
        issue_stall <= 1'b0;
        @(posedge clk);
        while (m_wr != m_rd)
            @(posedge clk);
        @(posedge clk);
        $display("%0d cycles checked, %0d errors", checked, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
